/* filelist.f */
hw/sc_cmd_pkg.sv
hw/sc_sample_pkg.sv
hw/sc_cmd_regs.sv
hw/sc_scan_ctrl.sv
hw/sc_sample_fifo.sv
hw/sc_readout.sv
hw/sample_collector_top.sv
tests/tb_sample_collector.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_sample_collector
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_sample_collector.sv */
// drives the collector with its default page 242 and depth 16; the source model answers every strobe
`default_nettype none

module tb_sample_collector;
  import sc_cmd_pkg::*;
  import sc_sample_pkg::*;

  // register map and opcodes as the host sees them
  localparam logic [7:0] PAGE        = 8'd242;
  localparam logic [7:0] OFF_UNIT    = 8'd4;
  localparam logic [7:0] OFF_COMMAND = 8'd5;
  localparam logic [7:0] OP_START    = 8'd1;
  localparam logic [7:0] OP_STOP     = 8'd2;
  localparam logic [7:0] OP_RESET    = 8'd5;

  // conditions the main sequence can wait for
  localparam int UNTIL_VALID   = 0;
  localparam int UNTIL_INVALID = 1;
  localparam int UNTIL_ALMOST  = 2;
  localparam int UNTIL_FULL    = 3;
  localparam int UNTIL_DRAINED = 4;
  localparam int UNTIL_READS   = 5;
  localparam int UNTIL_QUIET   = 6;

  logic        clk;
  logic        rst = 1'b1;
  sc_bus_wr_t  bus = '0;
  logic [7:0]  channel_select;
  logic        sample_strobe;
  logic [31:0] sample_data = '0;
  logic        rd_en = 1'b0;
  sc_entry_t   sample_out;
  logic        sample_valid;
  logic        fifo_full;
  logic        fifo_almost_full;

  // model of the channel table, the scan position and the kept values
  logic [7:0]  chan_tab [8] = '{default: 8'hff};
  logic [31:0] last_val [8] = '{default: '0};
  int          strobe_cnt [256];
  int          n_units = 0;
  int          scan_pos = 0;
  sc_entry_t   exp_q [$];

  logic strobe_q = 1'b0;
  logic read_on = 1'b0;
  logic gaps = 1'b0;
  int   quiet = 0;
  int   errors = 0;
  int   timeouts = 0;
  int   n_strobes = 0;
  int   n_changes = 0;
  int   n_reads = 0;

  sample_collector_top dut0 (
    .clk              (clk),
    .rst              (rst),
    .bus              (bus),
    .channel_select   (channel_select),
    .sample_strobe    (sample_strobe),
    .sample_data      (sample_data),
    .rd_en            (rd_en),
    .sample_out       (sample_out),
    .sample_valid     (sample_valid),
    .fifo_full        (fifo_full),
    .fifo_almost_full (fifo_almost_full)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // source word for a channel, step is half the strobe count so each word comes twice
  function automatic logic [31:0] source_word(input logic [7:0] ch, input int step);
    return {ch, 24'(step * 1229 + 7)} ^ 32'h5a00_0000;
  endfunction

  // change rule, an entry is due only when the word differs from the last kept one
  function automatic logic entry_due(input int idx, input logic [31:0] word,
                                     input logic [31:0] last, output sc_entry_t ent);
    ent.id   = 3'(idx);
    ent.data = word[12:0];
    return word != last;
  endfunction

  function automatic logic cond_met(input int kind, input int target);
    case (kind)
      UNTIL_VALID:   return sample_valid;
      UNTIL_INVALID: return !sample_valid;
      UNTIL_ALMOST:  return fifo_almost_full;
      UNTIL_FULL:    return fifo_full;
      UNTIL_DRAINED: return exp_q.size() == 0;
      UNTIL_READS:   return n_reads >= target;
      UNTIL_QUIET:   return quiet >= target;
      default:       return 1'b0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
      errors++;
      $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  task automatic wait_until(input int kind, input int target, input int limit, input string what);
    int n;
    n = 0;
    while (!cond_met(kind, target) && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (!cond_met(kind, target)) begin
      timeouts++;
      $display("timeout after %0d cycles waiting for %s", limit, what);
      finish_run();
    end
  endtask

  // one bus write is a single cycle with wr high
  task automatic bus_write(input logic [7:0] offset, input logic [7:0] value);
    @(posedge clk);
    bus <= '{addr: {PAGE, offset}, data: {24'd0, value}, wr: 1'b1};
    @(posedge clk);
    bus <= '0;
  endtask

  task automatic register_units(input int count);
    logic [7:0] ch;
    for (int i = 0; i < count; i++) begin
      ch = 8'($urandom % 256);
      chan_tab[i] = ch;
      bus_write(OFF_UNIT, ch);
    end
    n_units = count;
  endtask

  task automatic expect_no_strobe();
    int mark;
    mark = n_strobes;
    bus_write(OFF_COMMAND, OP_START);
    repeat (50) @(posedge clk);
    check_val("strobe count", mark, n_strobes);
  endtask

  task automatic stop_and_drain();
    bus_write(OFF_COMMAND, OP_STOP);
    wait_until(UNTIL_QUIET, 40, 2000, "strobes to end after stop");
    wait_until(UNTIL_DRAINED, 0, 2000, "the expected entries to drain");
    repeat (20) @(posedge clk);
    check_val("sample_valid", 32'(1'b0), 32'(sample_valid));
    check_val("entries read", n_changes, n_reads);
  endtask

  // source model, a strobe rise picks the next word and the change rule queues an entry
  always @(posedge clk) begin : source_model
    logic [31:0] word;
    sc_entry_t   ent;
    int          step;
    strobe_q <= sample_strobe;
    quiet    <= sample_strobe ? 0 : quiet + 1;
    if (!rst && sample_strobe && !strobe_q) begin
      n_strobes++;
      assert (n_units != 0) else begin
        errors++;
        $display("strobe at %0t while no unit is registered", $time);
      end
      if (n_units != 0) begin
        check_val("channel_select", 32'(chan_tab[scan_pos]), 32'(channel_select));
        step = strobe_cnt[channel_select] / 2;
        strobe_cnt[channel_select]++;
        word = source_word(channel_select, step);
        sample_data <= word;
        if (entry_due(scan_pos, word, last_val[scan_pos], ent)) begin
          exp_q.push_back(ent);
          last_val[scan_pos] = word;
          n_changes++;
        end
        scan_pos = (scan_pos + 1) % n_units;
      end
    end
  end

  // host reads, every cycle or with random gaps
  always @(posedge clk) begin : read_driver
    rd_en <= read_on && (!gaps || (($urandom % 4) != 32'd0));
  end

  // every word the host takes must be the oldest expected entry
  always @(posedge clk) begin : compare_words
    sc_entry_t want;
    if (!rst && sample_valid && rd_en) begin
      n_reads++;
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("word %0h read at %0t with no entry expected", sample_out, $time);
      end
      if (exp_q.size() != 0) begin
        want = exp_q.pop_front();
        check_val("sample_out", 32'(want), 32'(sample_out));
      end
    end
  end

  initial begin : main_seq
    int mark;
    mark = $urandom(12938);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    check_val("sample_strobe", 32'(1'b0), 32'(sample_strobe));
    check_val("sample_valid", 32'(1'b0), 32'(sample_valid));
    check_val("fifo_full", 32'(1'b0), 32'(fifo_full));
    check_val("fifo_almost_full", 32'(1'b0), 32'(fifo_almost_full));
    expect_no_strobe();

    // five units read without gaps
    register_units(5);
    read_on <= 1'b1;
    bus_write(OFF_COMMAND, OP_START);
    wait_until(UNTIL_READS, 40, 2000, "40 words read");

    // the host stays away, the buffer fills and the scan stalls
    read_on <= 1'b0;
    wait_until(UNTIL_ALMOST, 0, 300, "fifo_almost_full");
    check_val("fifo_full", 32'(1'b0), 32'(fifo_full));
    wait_until(UNTIL_FULL, 0, 300, "fifo_full");
    repeat (30) @(posedge clk);
    mark = n_strobes;
    repeat (200) @(posedge clk);
    check_val("strobes while full", mark, n_strobes);

    // reads come back with gaps, nothing may be lost or doubled
    gaps    <= 1'b1;
    read_on <= 1'b1;
    mark = n_reads;
    wait_until(UNTIL_READS, mark + 60, 3000, "60 more words read");
    stop_and_drain();

    // a word waits in the output when the reset command arrives
    read_on <= 1'b0;
    bus_write(OFF_COMMAND, OP_START);
    wait_until(UNTIL_VALID, 0, 200, "a word in the output");
    repeat (8) @(posedge clk);
    bus_write(OFF_COMMAND, OP_RESET);
    wait_until(UNTIL_INVALID, 0, 200, "sample_valid to fall after reset");
    repeat (5) @(posedge clk);
    // the flush dropped whatever was still queued, the model follows the cleared table
    n_changes = n_changes - exp_q.size();
    exp_q.delete();
    n_units  = 0;
    scan_pos = 0;
    for (int i = 0; i < 8; i++) begin
      last_val[i] = '0;
    end
    expect_no_strobe();

    // a fresh table scans from index 0 again
    register_units(3);
    read_on <= 1'b1;
    mark = n_reads;
    bus_write(OFF_COMMAND, OP_START);
    wait_until(UNTIL_READS, mark + 30, 2000, "30 words from the new table");
    stop_and_drain();
    finish_run();
  end

endmodule

`default_nettype wire

/* hw/sample_collector_top.sv */
// NUM_UNITS may be 1 to 8 and FIFO_DEPTH a power of two of at least 4; only bus writes, no register reads
`default_nettype none

module sample_collector_top #(
  parameter int POSITION   = 242,
  parameter int NUM_UNITS  = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  sc_cmd_pkg::sc_bus_wr_t   bus,
  output logic [7:0]               channel_select,
  output logic                     sample_strobe,
  input  logic [31:0]              sample_data,
  input  logic                     rd_en,
  output sc_sample_pkg::sc_entry_t sample_out,
  output logic                     sample_valid,
  output logic                     fifo_full,
  output logic                     fifo_almost_full
);
  import sc_cmd_pkg::*;
  import sc_sample_pkg::*;

  sc_cmd_e    cmd;
  logic       cmd_ack;
  logic [2:0] unit_idx;
  logic [7:0] unit_channel;
  logic [3:0] unit_count;
  logic       push;
  sc_entry_t  push_entry;
  logic       credit_return;
  logic       flush;
  logic       pop;
  sc_entry_t  pop_entry;
  logic       pop_valid;
  logic       fifo_empty;

  sc_cmd_regs #(
    .POSITION  (POSITION),
    .NUM_UNITS (NUM_UNITS)
  ) cmd_regs0 (
    .clk          (clk),
    .rst          (rst),
    .bus          (bus),
    .cmd          (cmd),
    .cmd_ack      (cmd_ack),
    .unit_idx     (unit_idx),
    .unit_channel (unit_channel),
    .unit_count   (unit_count)
  );

  // producer, spends one credit per stored entry
  sc_scan_ctrl #(
    .NUM_UNITS  (NUM_UNITS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) scan_ctrl0 (
    .clk            (clk),
    .rst            (rst),
    .cmd            (cmd),
    .cmd_ack        (cmd_ack),
    .unit_idx       (unit_idx),
    .unit_channel   (unit_channel),
    .unit_count     (unit_count),
    .channel_select (channel_select),
    .sample_strobe  (sample_strobe),
    .sample_data    (sample_data),
    .push           (push),
    .push_entry     (push_entry),
    .credit_return  (credit_return),
    .flush          (flush)
  );

  sc_sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .clk           (clk),
    .rst           (rst),
    .push          (push),
    .push_entry    (push_entry),
    .pop           (pop),
    .pop_entry     (pop_entry),
    .pop_valid     (pop_valid),
    .credit_return (credit_return),
    .flush         (flush),
    .empty         (fifo_empty),
    .full          (fifo_full),
    .almost_full   (fifo_almost_full)
  );

  // consumer, keeps the host word topped up from the buffer
  sc_readout readout0 (
    .clk          (clk),
    .rst          (rst),
    .pop          (pop),
    .pop_entry    (pop_entry),
    .pop_valid    (pop_valid),
    .fifo_empty   (fifo_empty),
    .flush        (flush),
    .rd_en        (rd_en),
    .sample_out   (sample_out),
    .sample_valid (sample_valid)
  );

endmodule

`default_nettype wire

/* hw/sc_readout.sv */
// one word is held for the host; rd_en while sample_valid is low has no effect
`default_nettype none

module sc_readout (
  input  logic                     clk,
  input  logic                     rst,
  output logic                     pop,
  input  sc_sample_pkg::sc_entry_t pop_entry,
  input  logic                     pop_valid,
  input  logic                     fifo_empty,
  input  logic                     flush,
  input  logic                     rd_en,
  output sc_sample_pkg::sc_entry_t sample_out,
  output logic                     sample_valid
);

  logic in_flight;
  logic slot_free;

  // the slot is free if empty now or being read on this edge
  assign slot_free = !sample_valid || rd_en;

  // no second request while the answer to the first is still on its way
  assign pop = slot_free && !in_flight && !fifo_empty && !flush;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      sample_valid <= 1'b0;
      in_flight    <= 1'b0;
    end else begin
      // the buffer answers exactly one cycle after the request
      in_flight <= pop;
      if (pop_valid) begin
        sample_valid <= 1'b1;
      end else if (rd_en) begin
        sample_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop_valid) begin
      sample_out <= pop_entry;
    end
  end

endmodule

`default_nettype wire

/* hw/sc_sample_fifo.sv */
// FIFO_DEPTH must be a power of two; a push into a full buffer is dropped, which credit flow prevents
`default_nettype none

module sc_sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  sc_sample_pkg::sc_entry_t push_entry,
  input  logic                     pop,
  output sc_sample_pkg::sc_entry_t pop_entry,
  output logic                     pop_valid,
  output logic                     credit_return,
  input  logic                     flush,
  output logic                     empty,
  output logic                     full,
  output logic                     almost_full
);
  import sc_sample_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  sc_entry_t mem [FIFO_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(FIFO_DEPTH));
  // two or fewer slots left
  assign almost_full = (count >= CNT_W'(FIFO_DEPTH - 2));
  assign do_push     = push && !full && !flush;
  assign do_pop      = pop && !empty && !flush;

  // every entry that leaves hands one credit back to the scan
  assign credit_return = pop_valid;

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_entry;
    end
    if (do_pop) begin
      pop_entry <= mem[rd_ptr];
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      pop_valid <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count     <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      pop_valid <= do_pop;
    end
  end

endmodule

`default_nettype wire

/* hw/sc_scan_ctrl.sv */
// the source must present sample_data by the second strobe cycle and hold it until the store decision is taken
`default_nettype none

module sc_scan_ctrl #(
  parameter int NUM_UNITS  = 8,
  parameter int FIFO_DEPTH = 16
) (
  input  logic                     clk,
  input  logic                     rst,
  input  sc_cmd_pkg::sc_cmd_e      cmd,
  output logic                     cmd_ack,
  output logic [2:0]               unit_idx,
  input  logic [7:0]               unit_channel,
  input  logic [3:0]               unit_count,
  output logic [7:0]               channel_select,
  output logic                     sample_strobe,
  input  logic [31:0]              sample_data,
  output logic                     push,
  output sc_sample_pkg::sc_entry_t push_entry,
  input  logic                     credit_return,
  output logic                     flush
);
  import sc_cmd_pkg::*;
  import sc_sample_pkg::*;

  localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

  sc_scan_e state;
  sc_scan_e state_next;

  logic [2:0]          idx_q;
  logic [CREDIT_W-1:0] credit_q;
  logic                sample_new;
  logic                advance_idx;
  logic                clear_idx;
  logic                clear_last;

  // last value that went into the buffer, per table slot
  logic [SAMPLE_W-1:0] last_q [NUM_UNITS];

  assign unit_idx       = idx_q;
  assign channel_select = unit_channel;
  assign sample_new     = (sample_data != last_q[idx_q]);
  assign push_entry     = '{id: idx_q, data: sample_data[DATA_W-1:0]};

  always_comb begin
    state_next    = state;
    cmd_ack       = 1'b0;
    flush         = 1'b0;
    sample_strobe = 1'b0;
    push          = 1'b0;
    advance_idx   = 1'b0;
    clear_idx     = 1'b0;
    clear_last    = 1'b0;
    case (state)
      scan_idle: begin
        // every command is taken here, start only runs with channels present
        case (cmd)
          cmd_start: begin
            cmd_ack = 1'b1;
            if (unit_count != 4'd0) begin
              state_next = scan_fetch;
            end
          end
          cmd_flush: begin
            cmd_ack = 1'b1;
            flush   = 1'b1;
          end
          cmd_stop: begin
            cmd_ack = 1'b1;
          end
          cmd_reset: begin
            cmd_ack    = 1'b1;
            flush      = 1'b1;
            clear_last = 1'b1;
            clear_idx  = 1'b1;
          end
          default: begin
            cmd_ack = 1'b0;
          end
        endcase
      end
      // two strobe cycles give the source time to set up its word
      scan_fetch: begin
        sample_strobe = 1'b1;
        state_next    = scan_fetch_wait;
      end
      scan_fetch_wait: begin
        sample_strobe = 1'b1;
        state_next    = scan_store;
      end
      // an unchanged sample costs nothing, a new one waits here for a credit
      scan_store: begin
        if (!sample_new) begin
          state_next = scan_advance;
        end else if (credit_q != '0) begin
          push       = 1'b1;
          state_next = scan_advance;
        end
      end
      scan_advance: begin
        advance_idx = 1'b1;
        state_next  = scan_fetch;
        if (cmd == cmd_reset) begin
          cmd_ack    = 1'b1;
          flush      = 1'b1;
          clear_last = 1'b1;
          clear_idx  = 1'b1;
          state_next = scan_idle;
        end else if (cmd == cmd_stop) begin
          cmd_ack    = 1'b1;
          state_next = scan_idle;
        end
      end
      default: begin
        state_next = scan_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= scan_idle;
    end else begin
      state <= state_next;
    end
  end

  // index steps round the registered channels, a reset restarts it at 0
  always_ff @(posedge clk) begin
    if (rst || clear_idx) begin
      idx_q <= 3'd0;
    end else if (advance_idx) begin
      if (({1'b0, idx_q} + 4'd1) >= unit_count) begin
        idx_q <= 3'd0;
      end else begin
        idx_q <= idx_q + 3'd1;
      end
    end
  end

  // a credit coming back and a push in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      credit_q <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      credit_q <= credit_q + CREDIT_W'(credit_return) - CREDIT_W'(push);
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear_last) begin
      for (int i = 0; i < NUM_UNITS; i++) begin
        last_q[i] <= '0;
      end
    end else if (push) begin
      last_q[idx_q] <= sample_data;
    end
  end

endmodule

`default_nettype wire

/* hw/sc_cmd_regs.sv */
// holds at most NUM_UNITS channels; writes beyond a full table and unknown opcodes are dropped silently
`default_nettype none

module sc_cmd_regs #(
  parameter int POSITION  = 242,
  parameter int NUM_UNITS = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  sc_cmd_pkg::sc_bus_wr_t bus,
  output sc_cmd_pkg::sc_cmd_e    cmd,
  input  logic                   cmd_ack,
  input  logic [2:0]             unit_idx,
  output logic [7:0]             unit_channel,
  output logic [3:0]             unit_count
);
  import sc_cmd_pkg::*;

  // channel numbers in registration order, 255 marks a free slot
  logic [7:0] chan_table [NUM_UNITS];

  logic page_hit;
  logic new_unit_wr;
  logic command_wr;
  logic table_full;
  logic opcode_ok;
  logic reset_ack;

  // a write belongs to this block only when the page byte matches
  assign page_hit    = bus.wr && (bus.addr[15:8] == 8'(POSITION));
  assign new_unit_wr = page_hit && (bus.addr[7:0] == ADDR_NEW_UNIT);
  assign command_wr  = page_hit && (bus.addr[7:0] == ADDR_LOCAL_COMMAND);
  assign table_full  = (unit_count >= 4'(NUM_UNITS));

  // the reset acknowledge wipes the table and wins over any write in that cycle
  assign reset_ack = cmd_ack && (cmd == cmd_reset);

  // only opcodes that the scan knows are latched
  always_comb begin
    case (bus.data[7:0])
      8'd1, 8'd2, 8'd3, 8'd5: opcode_ok = 1'b1;
      default:                opcode_ok = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_UNITS; i++) begin
        chan_table[i] <= 8'hff;
      end
      unit_count <= 4'd0;
      cmd        <= cmd_none;
    end else begin
      // the scan has taken the command, so it is gone
      if (cmd_ack) begin
        cmd <= cmd_none;
      end
      if (reset_ack) begin
        for (int i = 0; i < NUM_UNITS; i++) begin
          chan_table[i] <= 8'hff;
        end
        unit_count <= 4'd0;
      end else begin
        // new channels fill the next free slot
        if (new_unit_wr && !table_full) begin
          chan_table[unit_count[2:0]] <= bus.data[7:0];
          unit_count                  <= unit_count + 4'd1;
        end
        // a fresh command overrides whatever is still pending
        if (command_wr && opcode_ok) begin
          cmd <= sc_cmd_e'(bus.data[7:0]);
        end
      end
    end
  end

  // the scan picks the slot, slots past the table size read as empty
  always_comb begin
    unit_channel = 8'hff;
    if (int'(unit_idx) < NUM_UNITS) begin
      unit_channel = chan_table[unit_idx];
    end
  end

endmodule

`default_nettype wire

/* hw/sc_sample_pkg.sv */
// sample path types; a stored entry keeps only the low DATA_W bits of the sample next to its table index
`default_nettype none

package sc_sample_pkg;

  // width of the word a source presents on sample_data
  localparam int SAMPLE_W = 32;

  // index field, wide enough for a table of eight channels
  localparam int ID_W = 3;

  // data field, the low bits of the sample that fit beside the index
  localparam int DATA_W = 13;

  // one buffered entry, 16 bits, index in the upper bits
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
  } sc_entry_t;

  // states of the channel scan
  // fetch and fetch_wait hold the strobe, store decides and pushes,
  // advance moves the index and checks for stop or reset
  typedef enum logic [2:0] {
    scan_idle,
    scan_fetch,
    scan_fetch_wait,
    scan_store,
    scan_advance
  } sc_scan_e;

endpackage

`default_nettype wire

/* hw/sc_cmd_pkg.sv */
// command bus types; a bus write is a single-cycle wr pulse and only the low address byte selects a register
`default_nettype none

package sc_cmd_pkg;

  // register offsets inside the page selected by addr[15:8]
  // a write of data[7:0] to this offset appends one channel to the table
  localparam logic [7:0] ADDR_NEW_UNIT = 8'd4;

  // a write of data[7:0] to this offset posts a command opcode
  localparam logic [7:0] ADDR_LOCAL_COMMAND = 8'd5;

  // command opcodes as the host writes them into data[7:0]
  // value 4 is unused and the encoding keeps the gap
  typedef enum logic [7:0] {
    cmd_none  = 8'd0,
    cmd_start = 8'd1,
    cmd_stop  = 8'd2,
    cmd_flush = 8'd3,
    cmd_reset = 8'd5
  } sc_cmd_e;

  // one write on the host command bus
  // addr[15:8] carries the page and addr[7:0] the register offset
  // only data[7:0] matters for the registers defined so far
  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] data;
    logic        wr;
  } sc_bus_wr_t;

endpackage

`default_nettype wire
